// File: hdl/board_settings.svh
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

// Board clock in MHz
`define CLK_MHZ 50

// Board I/O counts
`define W_KEY   8
`define W_SW    8   // Top switch is the reset
`define W_LED   16
`define W_DIGIT 6

// I2S timing for the INMP441
`define I2S_SCK_DIV    8   // clk cycles per half bit clock
`define I2S_FRAME_BITS 64  // Bit clocks per ws frame, 32 per channel

// Display refresh, each digit lit for 2**REFRESH_BITS clk
`define REFRESH_BITS 10

`endif

// File: hdl/board_pkg.sv
`default_nettype none

`include "board_settings.svh"

package board_pkg;

    typedef logic signed [23:0] mic_sample_t;  // Raw two's complement sample
    typedef logic        [22:0] level_t;       // Magnitude, also peak level

    typedef logic [`W_LED   - 1:0] led_t;
    typedef logic [          7:0] seg_pattern_t;  // a..g then h (dot), a is msb
    typedef logic [`W_DIGIT - 1:0] digit_sel_t;    // One-hot, active high

    typedef logic [2:0] decay_sel_t;  // Peak shift is decay_sel + 1

    // Receiver FSM
    typedef enum logic [1:0] {
        wait_ws_fall,  // Idle until left channel starts
        skip_bit,      // Empty bit after ws falls
        shift_bits,    // 24 data bits, msb first
        wait_frame     // Rest of the frame ignored
    } i2s_state_t;

endpackage

`default_nettype wire

// File: hdl/inmp441_mic_i2s_receiver.sv
`timescale 1ns/100ps
`default_nettype none

`include "board_settings.svh"

module inmp441_mic_i2s_receiver (
    input  wire                    clk,
    input  wire                    rst,
    output logic                   ws,
    output logic                   sck,
    input  wire                    sd,
    output board_pkg::mic_sample_t value,
    output logic                   sample_valid
);
    import board_pkg::*;

    localparam int div_w       = $clog2(`I2S_SCK_DIV);
    localparam int frame_w     = $clog2(`I2S_FRAME_BITS);
    localparam int sample_bits = $bits(mic_sample_t);

    logic [div_w   - 1:0]     div_cnt;    // clk cycles within half bit
    logic [frame_w - 1:0]     bit_cnt;    // Bit clock position in frame
    logic [frame_w - 1:0]     bit_next;
    logic [4:0]               shift_cnt;  // Data bits taken so far
    logic [sample_bits - 2:0] shift_reg;  // Last bit goes straight to value
    logic                     ws_d;
    logic                     sck_edge, sck_rise, sck_fall;
    logic                     ws_fall, ws_rise;
    i2s_state_t               state;

    assign sck_edge = (div_cnt == div_w'(`I2S_SCK_DIV - 1));
    assign sck_rise = sck_edge && !sck;  // sck about to go high
    assign sck_fall = sck_edge &&  sck;
    assign bit_next = bit_cnt + 1'b1;
    assign ws_fall  =  ws_d && !ws;
    assign ws_rise  = !ws_d &&  ws;

    // Bit clock and word select
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            ws      <= 1'b0;
            ws_d    <= 1'b0;
        end else begin
            div_cnt <= sck_edge ? '0 : div_cnt + 1'b1;
            ws_d    <= ws;
            if (sck_edge)
                sck <= !sck;
            if (sck_fall) begin  // ws moves on falling sck only
                bit_cnt <= bit_next;
                ws      <= bit_next[frame_w - 1];  // High for the right half
            end
        end
    end

    // Deserializer shifts on rising sck
    always_ff @(posedge clk)
        if (state == shift_bits && sck_rise)
            shift_reg <= {shift_reg[sample_bits - 3:0], sd};

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= wait_ws_fall;
            shift_cnt    <= '0;
            value        <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;  // Single clk strobe
            case (state)
                wait_ws_fall:
                    if (ws_fall)
                        state <= skip_bit;
                skip_bit:
                    if (sck_rise) begin  // Delay bit carries no data
                        state     <= shift_bits;
                        shift_cnt <= '0;
                    end
                shift_bits:
                    if (sck_rise) begin
                        shift_cnt <= shift_cnt + 1'b1;
                        if (shift_cnt == 5'(sample_bits - 1)) begin
                            value        <= {shift_reg, sd};
                            sample_valid <= 1'b1;
                            state        <= wait_frame;
                        end
                    end
                wait_frame:
                    if (ws_rise)  // Rearm once the right channel starts
                        state <= wait_ws_fall;
                default:
                    state <= wait_ws_fall;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/peak_level_tracker.sv
`timescale 1ns/100ps
`default_nettype none

`include "board_settings.svh"

module peak_level_tracker (
    input  wire                    clk,
    input  wire                    rst,
    input  wire board_pkg::mic_sample_t sample,
    input  wire                    sample_valid,
    input  wire board_pkg::decay_sel_t  decay_sel,
    output board_pkg::led_t        led
);
    import board_pkg::*;

    mic_sample_t neg;        // Negated sample
    level_t      mag;        // |sample|, saturated
    level_t      peak;
    level_t      decayed;    // Peak after one decay step
    level_t      peak_next;
    logic [3:0]  shift;
    led_t        bar;        // Thermometer of the current peak

    assign neg = -sample;

    always_comb begin
        if (!sample[23])
            mag = sample[22:0];
        else if (neg[23])    // Most negative value has no positive twin
            mag = '1;
        else
            mag = neg[22:0];
    end

    assign shift     = {1'b0, decay_sel} + 4'd1;
    assign decayed   = peak - (peak >> shift);
    assign peak_next = (mag >= decayed) ? mag : decayed;  // Replace or decay

    // LED i lights at 2**(i + 7) and above
    always_comb begin
        for (int i = 0; i < `W_LED; i++)
            bar[i] = (peak >= (level_t'(1) << (i + 7)));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            peak <= '0;
            led  <= '0;
        end else begin
            if (sample_valid)
                peak <= peak_next;  // Once per strobe
            led <= bar;             // One clk behind the peak
        end
    end

endmodule

`default_nettype wire

// File: hdl/seven_segment_display.sv
`timescale 1ns/100ps
`default_nettype none

`include "board_settings.svh"

module seven_segment_display (
    input  wire                         clk,
    input  wire                         rst,
    input  wire board_pkg::mic_sample_t number,
    output board_pkg::seg_pattern_t     abcdefgh,
    output board_pkg::digit_sel_t       digit
);
    import board_pkg::*;

    localparam int idx_w = $clog2(`W_DIGIT);

    logic [`REFRESH_BITS - 1:0] refresh_cnt;  // Time on one digit
    logic [idx_w - 1:0]         idx;          // Digit currently lit
    logic [idx_w - 1:0]         idx_next;
    logic [3:0]                 nibble_next;

    // Hex glyphs, segments a..g with the dot off
    function automatic seg_pattern_t hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0: hex_to_seg = 8'b1111_1100;
            4'h1: hex_to_seg = 8'b0110_0000;
            4'h2: hex_to_seg = 8'b1101_1010;
            4'h3: hex_to_seg = 8'b1111_0010;
            4'h4: hex_to_seg = 8'b0110_0110;
            4'h5: hex_to_seg = 8'b1011_0110;
            4'h6: hex_to_seg = 8'b1011_1110;
            4'h7: hex_to_seg = 8'b1110_0000;
            4'h8: hex_to_seg = 8'b1111_1110;
            4'h9: hex_to_seg = 8'b1111_0110;
            4'ha: hex_to_seg = 8'b1110_1110;
            4'hb: hex_to_seg = 8'b0011_1110;  // Lower case b
            4'hc: hex_to_seg = 8'b1001_1100;
            4'hd: hex_to_seg = 8'b0111_1010;  // Lower case d
            4'he: hex_to_seg = 8'b1001_1110;
            4'hf: hex_to_seg = 8'b1000_1110;
        endcase
    endfunction

    assign idx_next    = (idx == idx_w'(`W_DIGIT - 1)) ? '0 : idx + 1'b1;
    assign nibble_next = number[idx_next * 4 +: 4];

    always_ff @(posedge clk) begin
        if (rst) begin
            refresh_cnt <= '0;
            idx         <= '0;
            digit       <= digit_sel_t'(1);  // Start at the low digit
            abcdefgh    <= hex_to_seg(4'h0);
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
            if (&refresh_cnt) begin
                // Select and pattern switch together
                idx      <= idx_next;
                digit    <= digit_sel_t'(1) << idx_next;
                abcdefgh <= hex_to_seg(nibble_next);
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/top.sv
`timescale 1ns/100ps
`default_nettype none

`include "board_settings.svh"

module top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire [`W_KEY - 1:0]          key,        // Active high
    input  wire [`W_SW  - 2:0]          sw,         // Non-reset switches
    input  wire board_pkg::mic_sample_t mic,
    input  wire                         mic_valid,
    output board_pkg::led_t             led,
    output board_pkg::seg_pattern_t     abcdefgh,
    output board_pkg::digit_sel_t       digit
);
    import board_pkg::*;

    mic_sample_t shown;      // Value on the display
    decay_sel_t  decay_sel;

    assign decay_sel = sw[2:0];

    // Key 0 freezes the display
    always_ff @(posedge clk) begin
        if (rst)
            shown <= '0;
        else if (mic_valid && !key[0])
            shown <= mic;
    end

    // LED bar keeps running while the display is frozen
    peak_level_tracker i_peak (
        .clk          ( clk       ),
        .rst          ( rst       ),
        .sample       ( mic       ),
        .sample_valid ( mic_valid ),
        .decay_sel    ( decay_sel ),
        .led          ( led       )
    );

    seven_segment_display i_display (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .number   ( shown    ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

`default_nettype wire

// File: hdl/board_specific_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "board_settings.svh"

module board_specific_top (
    input  wire                    CLK,

    input  wire [`W_KEY   - 1:0]   KEY_N,    // Low when pressed
    input  wire [`W_SW    - 1:0]   SW,

    output wire [`W_LED   - 1:0]   LED,

    output wire [            7:0]  ABCDEFGH,
    output wire [`W_DIGIT - 1:0]   DIGIT_N,  // Low selects a digit

    input  wire                    UART_RX,
    output wire                    UART_TX,

    inout  wire [           22:2]  GPIO_P1,  // Header pins 2..22
    inout  wire [           22:2]  GPIO_P2
);
    import board_pkg::*;

    wire          clk = CLK;
    wire          rst = SW[`W_SW - 1];      // Top switch resets everything
    wire [`W_SW - 2:0] top_sw = SW[`W_SW - 2:0];

    mic_sample_t  mic;        // Latest left channel sample
    wire          mic_valid;
    seg_pattern_t abcdefgh;
    digit_sel_t   digit;

    top i_top (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .key       ( ~KEY_N    ),  // Keys to active high
        .sw        ( top_sw    ),
        .mic       ( mic       ),
        .mic_valid ( mic_valid ),
        .led       ( LED       ),
        .abcdefgh  ( abcdefgh  ),
        .digit     ( digit     )
    );

    assign ABCDEFGH = abcdefgh;
    assign DIGIT_N  = ~digit;

    assign UART_TX = 1'b1;  // Line idle

    // Unused header pins float
    assign GPIO_P1[15:2]  = 'z;
    assign GPIO_P1[22:20] = 'z;
    assign GPIO_P2        = 'z;

    assign GPIO_P1[16] = 1'b0;  // lr low, mic drives left slot

    inmp441_mic_i2s_receiver i_microphone (
        .clk          ( clk         ),
        .rst          ( rst         ),
        .ws           ( GPIO_P1[17] ),
        .sck          ( GPIO_P1[18] ),
        .sd           ( GPIO_P1[19] ),  // Driven by the mic
        .value        ( mic         ),
        .sample_valid ( mic_valid   )
    );

endmodule

`default_nettype wire

// File: verif/tb_board_specific_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "board_settings.svh"

module tb_board_specific_top;
    import board_pkg::*;

    localparam int wait_limit  = 2000;  // Half a frame is 512 clk
    localparam int digit_limit = 8000;  // One full display rotation and a bit

    logic                  clk;
    logic [`W_KEY - 1:0]   key_n;
    logic [`W_SW  - 1:0]   sw;
    logic                  uart_rx;
    logic                  sd = 1'b0;  // Mic data into the header
    wire  [`W_LED - 1:0]   led;
    wire  [7:0]            abcdefgh;
    wire  [`W_DIGIT - 1:0] digit_n;
    wire                   uart_tx;
    wire  [22:2]           gpio_p1;
    wire  [22:2]           gpio_p2;
    wire                   ws  = gpio_p1[17];
    wire                   sck = gpio_p1[18];

    // Microphone model state
    mic_sample_t cur_sample = '0;  // Goes out in the next left slot
    mic_sample_t tx_word    = '0;
    int          slot_bit   = 99;
    logic        sck_last   = 1'b0;
    logic        ws_last    = 1'b0;
    logic [31:0] lcg_state  = 32'h3eb5;

    assign gpio_p1[19] = sd;

    board_specific_top board_specific_top_inst (
        .CLK      ( clk      ),
        .KEY_N    ( key_n    ),
        .SW       ( sw       ),
        .LED      ( led      ),
        .ABCDEFGH ( abcdefgh ),
        .DIGIT_N  ( digit_n  ),
        .UART_RX  ( uart_rx  ),
        .UART_TX  ( uart_tx  ),
        .GPIO_P1  ( gpio_p1  ),
        .GPIO_P2  ( gpio_p2  )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Glyph to nibble with bit 4 set for a known pattern
    function automatic logic [4:0] seg_to_hex(input seg_pattern_t seg);
        case (seg)
            8'b1111_1100: seg_to_hex = {1'b1, 4'h0};
            8'b0110_0000: seg_to_hex = {1'b1, 4'h1};
            8'b1101_1010: seg_to_hex = {1'b1, 4'h2};
            8'b1111_0010: seg_to_hex = {1'b1, 4'h3};
            8'b0110_0110: seg_to_hex = {1'b1, 4'h4};
            8'b1011_0110: seg_to_hex = {1'b1, 4'h5};
            8'b1011_1110: seg_to_hex = {1'b1, 4'h6};
            8'b1110_0000: seg_to_hex = {1'b1, 4'h7};
            8'b1111_1110: seg_to_hex = {1'b1, 4'h8};
            8'b1111_0110: seg_to_hex = {1'b1, 4'h9};
            8'b1110_1110: seg_to_hex = {1'b1, 4'ha};
            8'b0011_1110: seg_to_hex = {1'b1, 4'hb};  // Lower case
            8'b1001_1100: seg_to_hex = {1'b1, 4'hc};
            8'b0111_1010: seg_to_hex = {1'b1, 4'hd};  // Lower case
            8'b1001_1110: seg_to_hex = {1'b1, 4'he};
            8'b1000_1110: seg_to_hex = {1'b1, 4'hf};
            default:      seg_to_hex = 5'h00;
        endcase
    endfunction

    // I2S microphone model drives sd right after a falling sck
    always @(negedge clk) begin
        if (sck_last && !sck) begin
            if (ws_last && !ws) begin  // Left slot opens with the empty bit
                tx_word  <= cur_sample;
                slot_bit <= 0;
                sd       <= 1'b0;
            end else if (!ws) begin
                if (slot_bit < $bits(mic_sample_t)) begin
                    sd       <= tx_word[23];  // Msb first
                    tx_word  <= tx_word << 1;
                    slot_bit <= slot_bit + 1;
                end else begin
                    sd <= 1'b0;
                end
            end else begin
                lcg_state <= lcg_next(lcg_state);
                sd        <= lcg_state[16];  // Right slot noise
            end
        end
        sck_last <= sck;
        ws_last  <= ws;
    end

    task automatic stop_with_failure;
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_display(input string name, input mic_sample_t expected,
                                 input mic_sample_t actual);
        if (actual !== expected) begin
            $display("mismatch %s display: expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_led(input string name, input led_t expected, input led_t actual);
        if (actual !== expected) begin
            $display("mismatch %s led: expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_line(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic wait_ws(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (ws !== level && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (ws !== level) begin
            $display("timeout: word select never went to %b during %s", level, what);
            stop_with_failure();
        end
    endtask

    // Waits for a fresh select so the glyph reflects the current value
    task automatic wait_digit_start(input int k);
        int cycles;
        cycles = 0;
        while (digit_n[k] !== 1'b1 && cycles < digit_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (digit_n[k] !== 1'b1) begin
            $display("timeout: digit %0d never released", k);
            stop_with_failure();
        end
        cycles = 0;
        while (digit_n[k] !== 1'b0 && cycles < digit_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (digit_n[k] !== 1'b0) begin
            $display("timeout: digit %0d never selected", k);
            stop_with_failure();
        end
    endtask

    task automatic read_display(output mic_sample_t value);
        logic [4:0] glyph;
        value = '0;
        for (int k = 0; k < `W_DIGIT; k++) begin
            wait_digit_start(k);
            glyph = seg_to_hex(abcdefgh);
            if (!glyph[4]) begin
                $display("unknown segment pattern %b on digit %0d", abcdefgh, k);
                stop_with_failure();
            end
            value[k * 4 +: 4] = glyph[3:0];
        end
    endtask

    // One left slot carries the sample before the LED and display checks
    task automatic run_test(input string name, input mic_sample_t sample,
                            input decay_sel_t decay, input logic hold,
                            input mic_sample_t exp_disp, input led_t exp_led,
                            input logic read_back);
        mic_sample_t shown;
        wait_ws(1'b1, {name, " setup"});  // Model latches the sample at the next ws fall
        cur_sample = sample;
        sw[2:0]    = decay;
        key_n[0]   = !hold;
        wait_ws(1'b0, {name, " left slot"});
        wait_ws(1'b1, {name, " slot end"});  // Strobe and LED update are done
        check_led(name, exp_led, led);
        if (read_back) begin
            read_display(shown);
            check_display(name, exp_disp, shown);
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          rows;
        string       line;
        string       name;
        logic [31:0] f_sample, f_decay, f_hold, f_disp, f_led;
        logic        prev_hold;
        mic_sample_t prev_disp;
        logic        read_back;
        key_n     = '1;
        sw        = 8'h80;  // Reset switch up
        uart_rx   = 1'b1;
        rows      = 0;
        prev_hold = 1'b0;
        prev_disp = '0;
        repeat (2) @(negedge clk);
        sw[`W_SW - 1] = 1'b0;
        check_led("reset", '0, led);
        check_line("reset uart_tx", 1'b1, uart_tx);
        check_line("reset lr", 1'b0, gpio_p1[16]);  // Mic channel select
        fd = $fopen("verif/mic_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/mic_stimulus.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "/") begin  // Skip comment lines
                n = $sscanf(line, "%s %h %h %h %h %h",
                            name, f_sample, f_decay, f_hold, f_disp, f_led);
                if (n == 6) begin
                    // Frozen display rows after the first skip the slow readback
                    read_back = !f_hold[0] || !prev_hold || (f_disp[23:0] != prev_disp);
                    run_test(name, f_sample[23:0], f_decay[2:0], f_hold[0],
                             f_disp[23:0], f_led[15:0], read_back);
                    prev_hold = f_hold[0];
                    prev_disp = f_disp[23:0];
                    rows++;
                end else if (n > 0) begin
                    $display("malformed stimulus line: %s", line);
                    stop_with_failure();
                end
            end
        end
        $fclose(fd);
        if (rows == 0) begin
            $display("no test rows found in the stimulus file");
            stop_with_failure();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/board_pkg.sv
hdl/inmp441_mic_i2s_receiver.sv
hdl/peak_level_tracker.sv
hdl/seven_segment_display.sv
hdl/top.sv
hdl/board_specific_top.sv
verif/tb_board_specific_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for the pass line
set -u

cd "$(dirname "$0")" || exit 1

tb_top=tb_board_specific_top
build_dir=obj_dir
log_file=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --timescale 1ns/100ps -f files.f \
    --top-module "$tb_top" -Mdir "$build_dir" -o "$tb_top"
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$build_dir/$tb_top" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -qx "NO ERRORS" "$log_file"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $log_file"
exit 1

// File: verif/mic_stimulus.txt
// name sample decay_sel hold expected_display expected_led, values in hex
// hold 1 keeps key 0 pressed while the frame is received
after_reset     000000 0 0 000000 0000
positive        123456 0 0 123456 3fff
negative        f6dcba 0 0 f6dcba 1fff
d0_loud         400000 0 0 400000 ffff
d0_hold         c00000 0 1 400000 ffff
d0_step1        000000 0 1 400000 7fff
d0_step2        000000 0 1 400000 3fff
d0_step3        000000 0 1 400000 1fff
d0_release      1468ac 3 0 1468ac 3fff
d3_loud         220000 3 0 220000 7fff
d3_hold         de0000 3 1 220000 7fff
d3_step1        000000 3 1 220000 3fff
d3_step2        000000 3 1 220000 3fff
d3_release      5a5a5a 3 0 5a5a5a ffff
noise_ignored   79e7f9 3 0 79e7f9 ffff
min_negative    800000 3 0 800000 ffff
